// File: rtl/db_pkg.sv
package db_pkg;

    // --------------------------------------------------
    // Default field widths
    // --------------------------------------------------
    localparam int DEF_KEY_WID   = 8;
    localparam int DEF_VALUE_WID = 16;

    // --------------------------------------------------
    // Command opcodes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        OP_PUSH   = 2'd0,
        OP_POP    = 2'd1,
        OP_LOOKUP = 2'd2
    } db_op_t;

    // --------------------------------------------------
    // Command front end states
    // --------------------------------------------------
    // Idle, request issued and awaiting ack, response held
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_RSP  = 2'd2
    } db_core_state_t;

endpackage : db_pkg

// File: rtl/db_intf.sv
`timescale 1ns/1ps

interface db_intf #(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 16
) ();

    // Request side
    logic                 req;
    logic                 next;
    logic [KEY_WID-1:0]   key;
    logic [VALUE_WID-1:0] value;

    // Response side
    logic                 rdy;
    logic                 ack;
    logic                 error;
    logic                 hit;
    logic [KEY_WID-1:0]   rsp_key;
    logic [VALUE_WID-1:0] rsp_value;

    modport requester (
        output req,
        output next,
        output key,
        output value,
        input  rdy,
        input  ack,
        input  error,
        input  hit,
        input  rsp_key,
        input  rsp_value
    );

    modport responder (
        input  req,
        input  next,
        input  key,
        input  value,
        output rdy,
        output ack,
        output error,
        output hit,
        output rsp_key,
        output rsp_value
    );

endinterface : db_intf

// File: rtl/db_fifo_ctrl.sv
`timescale 1ns/1ps

module db_fifo_ctrl #(
    parameter int SIZE = 8
) (
    input  logic                      clk,
    input  logic                      srst,
    input  logic                      push_req,
    input  logic                      pop_req,
    output logic                      push_safe,
    output logic                      pop_safe,
    output logic [$clog2(SIZE+1)-1:0] count,
    output logic                      full,
    output logic                      empty
);

    localparam int CNT_WID = $clog2(SIZE + 1);

    // --------------------------------------------------
    // Overflow and underflow protection
    // --------------------------------------------------
    assign push_safe = push_req && !full;
    assign pop_safe  = pop_req && !empty;

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            count <= '0;
        end else if (push_safe && !pop_safe) begin
            count <= count + CNT_WID'(1);
        end else if (pop_safe && !push_safe) begin
            count <= count - CNT_WID'(1);
        end
    end

    // Status follows the count directly
    assign full  = (count == CNT_WID'(SIZE));
    assign empty = (count == '0);

endmodule : db_fifo_ctrl

// File: rtl/db_stash_fifo.sv
`timescale 1ns/1ps

module db_stash_fifo #(
    parameter int SIZE      = 8,
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 16
) (
    input  logic                      clk,
    input  logic                      __srst,
    input  logic                      init,
    output logic                      init_done,
    db_intf.responder                 wr_if,
    db_intf.responder                 rd_if,
    output logic [$clog2(SIZE+1)-1:0] fill,
    output logic                      full,
    output logic                      empty
);

    localparam int IDX_WID = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int CNT_WID = $clog2(SIZE + 1);

    logic                 db_srst;

    logic [KEY_WID-1:0]   key_mem   [SIZE];
    logic [VALUE_WID-1:0] value_mem [SIZE];
    logic [SIZE-1:0]      entry_vld;

    logic                 push_req;
    logic                 pop_req;
    logic                 push_safe;
    logic                 pop_safe;
    logic [CNT_WID-1:0]   count;
    logic [IDX_WID-1:0]   tail_idx;

    logic                 match;
    logic [IDX_WID-1:0]   match_idx;

    // --------------------------------------------------
    // Local reset and init
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || init) begin
            db_srst <= 1'b1;
        end else begin
            db_srst <= 1'b0;
        end
    end

    // Ready one cycle after the local reset drops
    always_ff @(posedge clk) begin
        if (__srst || db_srst) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Occupancy control
    // --------------------------------------------------
    assign push_req = wr_if.req && wr_if.rdy && !wr_if.next;
    assign pop_req  = rd_if.req && rd_if.rdy && rd_if.next;

    db_fifo_ctrl #(
        .SIZE (SIZE)
    ) i_db_fifo_ctrl (
        .clk       (clk),
        .srst      (db_srst),
        .push_req  (push_req),
        .pop_req   (pop_req),
        .push_safe (push_safe),
        .pop_safe  (pop_safe),
        .count     (count),
        .full      (full),
        .empty     (empty)
    );

    assign fill = count;

    // Oldest entry sits just below the count
    assign tail_idx = IDX_WID'(count - CNT_WID'(1));

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    // New entries enter at index 0, older ones move up
    always_ff @(posedge clk) begin
        if (push_safe) begin
            for (int i = SIZE - 1; i > 0; i--) begin
                key_mem[i]   <= key_mem[i-1];
                value_mem[i] <= value_mem[i-1];
            end
            key_mem[0]   <= wr_if.key;
            value_mem[0] <= wr_if.value;
        end
    end

    always_ff @(posedge clk) begin
        if (db_srst) begin
            entry_vld <= '0;
        end else if (push_safe) begin
            for (int i = SIZE - 1; i > 0; i--) begin
                entry_vld[i] <= entry_vld[i-1];
            end
            entry_vld[0] <= 1'b1;
        end else if (pop_safe) begin
            entry_vld[tail_idx] <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Key search
    // --------------------------------------------------
    // Lowest matching index wins, i.e. the newest entry
    always_comb begin
        match     = 1'b0;
        match_idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (entry_vld[i] && (key_mem[i] == rd_if.key)) begin
                match     = 1'b1;
                match_idx = IDX_WID'(i);
            end
        end
    end

    // --------------------------------------------------
    // Write side response
    // --------------------------------------------------
    assign wr_if.rdy       = init_done;
    assign wr_if.hit       = 1'b0;
    assign wr_if.rsp_key   = '0;
    assign wr_if.rsp_value = '0;

    always_ff @(posedge clk) begin
        if (db_srst) begin
            wr_if.ack <= 1'b0;
        end else begin
            wr_if.ack <= wr_if.req && wr_if.rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_if.req) begin
            wr_if.error <= full;
        end
    end

    // --------------------------------------------------
    // Read side response
    // --------------------------------------------------
    assign rd_if.rdy = init_done;

    always_ff @(posedge clk) begin
        if (db_srst) begin
            rd_if.ack <= 1'b0;
        end else begin
            rd_if.ack <= rd_if.req && rd_if.rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_if.req) begin
            if (rd_if.next) begin
                // Pop returns the oldest entry
                rd_if.error     <= empty;
                rd_if.hit       <= !empty;
                rd_if.rsp_key   <= empty ? '0 : key_mem[tail_idx];
                rd_if.rsp_value <= empty ? '0 : value_mem[tail_idx];
            end else begin
                rd_if.error     <= 1'b0;
                rd_if.hit       <= match;
                rd_if.rsp_key   <= match ? key_mem[match_idx] : '0;
                rd_if.rsp_value <= match ? value_mem[match_idx] : '0;
            end
        end
    end

endmodule : db_stash_fifo

// File: rtl/db_core.sv
`timescale 1ns/1ps

module db_core #(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 16
) (
    input  logic                 clk,
    input  logic                 __srst,
    input  logic                 init_done,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  db_pkg::db_op_t       cmd_op,
    input  logic [KEY_WID-1:0]   cmd_key,
    input  logic [VALUE_WID-1:0] cmd_value,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output logic                 rsp_hit,
    output logic                 rsp_error,
    output logic [KEY_WID-1:0]   rsp_key,
    output logic [VALUE_WID-1:0] rsp_value,
    db_intf.requester            wr_if,
    db_intf.requester            rd_if
);

    import db_pkg::*;

    db_core_state_t       state;
    logic                 req_pend;
    logic                 cmd_acc;

    db_op_t               op_q;
    logic [KEY_WID-1:0]   key_q;
    logic [VALUE_WID-1:0] value_q;

    assign cmd_ready = (state == ST_IDLE) && init_done;
    assign cmd_acc   = cmd_valid && cmd_ready;
    assign rsp_valid = (state == ST_RSP);

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state    <= ST_IDLE;
            req_pend <= 1'b0;
        end else begin
            req_pend <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_acc) begin
                        state    <= ST_REQ;
                        req_pend <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (wr_if.ack || rd_if.ack) begin
                        state <= ST_RSP;
                    end else if (!req_pend && !init_done) begin
                        // Stash was cleared under the request
                        state <= ST_IDLE;
                    end
                end
                ST_RSP: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command capture
    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            op_q    <= cmd_op;
            key_q   <= cmd_key;
            value_q <= cmd_value;
        end
    end

    // --------------------------------------------------
    // Stash requests
    // --------------------------------------------------
    assign wr_if.req   = req_pend && (op_q == OP_PUSH) && wr_if.rdy;
    assign wr_if.next  = 1'b0;
    assign wr_if.key   = key_q;
    assign wr_if.value = value_q;

    assign rd_if.req   = req_pend && (op_q != OP_PUSH) && rd_if.rdy;
    assign rd_if.next  = (op_q == OP_POP);
    assign rd_if.key   = key_q;
    assign rd_if.value = '0;

    // --------------------------------------------------
    // Response register
    // --------------------------------------------------
    // Held unchanged until the response is taken
    always_ff @(posedge clk) begin
        if (state == ST_REQ) begin
            if (wr_if.ack) begin
                rsp_error <= wr_if.error;
                rsp_hit   <= 1'b0;
                rsp_key   <= '0;
                rsp_value <= '0;
            end else if (rd_if.ack) begin
                rsp_error <= rd_if.error;
                rsp_hit   <= rd_if.hit;
                rsp_key   <= rd_if.rsp_key;
                rsp_value <= rd_if.rsp_value;
            end
        end
    end

endmodule : db_core

// File: rtl/db_stash_top.sv
`timescale 1ns/1ps

module db_stash_top #(
    parameter int SIZE      = 8,
    parameter int KEY_WID   = db_pkg::DEF_KEY_WID,
    parameter int VALUE_WID = db_pkg::DEF_VALUE_WID
) (
    input  logic                      clk,
    input  logic                      __srst,

    // Command channel
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  db_pkg::db_op_t            cmd_op,
    input  logic [KEY_WID-1:0]        cmd_key,
    input  logic [VALUE_WID-1:0]      cmd_value,

    // Response channel
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic                      rsp_hit,
    output logic                      rsp_error,
    output logic [KEY_WID-1:0]        rsp_key,
    output logic [VALUE_WID-1:0]      rsp_value,

    // Init and status
    input  logic                      init,
    output logic                      init_done,
    output logic [$clog2(SIZE+1)-1:0] fill,
    output logic                      full,
    output logic                      empty
);

    db_intf #(.KEY_WID(KEY_WID), .VALUE_WID(VALUE_WID)) db_wr_if ();
    db_intf #(.KEY_WID(KEY_WID), .VALUE_WID(VALUE_WID)) db_rd_if ();

    db_core #(
        .KEY_WID   (KEY_WID),
        .VALUE_WID (VALUE_WID)
    ) i_db_core (
        .clk       (clk),
        .__srst    (__srst),
        .init_done (init_done),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_key   (cmd_key),
        .cmd_value (cmd_value),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_hit   (rsp_hit),
        .rsp_error (rsp_error),
        .rsp_key   (rsp_key),
        .rsp_value (rsp_value),
        .wr_if     (db_wr_if.requester),
        .rd_if     (db_rd_if.requester)
    );

    db_stash_fifo #(
        .SIZE      (SIZE),
        .KEY_WID   (KEY_WID),
        .VALUE_WID (VALUE_WID)
    ) i_db_stash_fifo (
        .clk       (clk),
        .__srst    (__srst),
        .init      (init),
        .init_done (init_done),
        .wr_if     (db_wr_if.responder),
        .rd_if     (db_rd_if.responder),
        .fill      (fill),
        .full      (full),
        .empty     (empty)
    );

endmodule : db_stash_top

// File: verif/db_stash_properties.sv
`timescale 1ns/1ps

module db_stash_properties #(
    parameter int SIZE      = 8,
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 16
) (
    input logic                      clk,
    input logic                      __srst,
    input logic                      cmd_ready,
    input logic                      init_done,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input logic                      rsp_hit,
    input logic                      rsp_error,
    input logic [KEY_WID-1:0]        rsp_key,
    input logic [VALUE_WID-1:0]      rsp_value,
    input logic [$clog2(SIZE+1)-1:0] fill,
    input logic                      full,
    input logic                      empty
);

    // --------------------------------------------------
    // Command channel
    // --------------------------------------------------
    ready_needs_init: assert property (@(posedge clk) disable iff (__srst)
        cmd_ready |-> init_done)
        else $error("cmd_ready high while init_done low");

    // --------------------------------------------------
    // Response channel
    // --------------------------------------------------
    // Held response must not move under back-pressure
    rsp_held_stable: assert property (@(posedge clk) disable iff (__srst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_hit) && $stable(rsp_error)
            && $stable(rsp_key) && $stable(rsp_value)))
        else $error("response changed while waiting for rsp_ready");

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    full_not_empty: assert property (@(posedge clk) disable iff (__srst)
        !(full && empty))
        else $error("full and empty both high");

    fill_in_range: assert property (@(posedge clk) disable iff (__srst)
        int'(fill) <= SIZE)
        else $error("fill above stash size");

endmodule : db_stash_properties

bind db_stash_top db_stash_properties #(
    .SIZE      (SIZE),
    .KEY_WID   (KEY_WID),
    .VALUE_WID (VALUE_WID)
) u_db_stash_properties (
    .clk       (clk),
    .__srst    (__srst),
    .cmd_ready (cmd_ready),
    .init_done (init_done),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_hit   (rsp_hit),
    .rsp_error (rsp_error),
    .rsp_key   (rsp_key),
    .rsp_value (rsp_value),
    .fill      (fill),
    .full      (full),
    .empty     (empty)
);

// File: verif/db_stash_tb.sv
`timescale 1ns/1ps

module db_stash_tb;

    import db_pkg::*;

    localparam int SIZE      = 8;
    localparam int KEY_WID   = 8;
    localparam int VALUE_WID = 16;
    localparam int CNT_WID   = $clog2(SIZE + 1);
    localparam int TIMEOUT   = 200;

    logic                      clk;
    logic                      __srst;
    logic                      cmd_valid;
    logic                      cmd_ready;
    db_op_t                    cmd_op;
    logic [KEY_WID-1:0]        cmd_key;
    logic [VALUE_WID-1:0]      cmd_value;
    logic                      rsp_valid;
    logic                      rsp_ready;
    logic                      rsp_hit;
    logic                      rsp_error;
    logic [KEY_WID-1:0]        rsp_key;
    logic [VALUE_WID-1:0]      rsp_value;
    logic                      init;
    logic                      init_done;
    logic [$clog2(SIZE+1)-1:0] fill;
    logic                      full;
    logic                      empty;

    // Reference model, newest entry at index 0
    logic [KEY_WID-1:0]        model_keys[$];
    logic [VALUE_WID-1:0]      model_values[$];

    logic [31:0]               rng;
    int                        errors;
    int                        commands;
    int                        responses;

    db_stash_top #(
        .SIZE      (SIZE),
        .KEY_WID   (KEY_WID),
        .VALUE_WID (VALUE_WID)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Errors: %0d, commands: %0d, responses: %0d", errors, commands, responses);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_init(input logic level, input string what);
        int tmo;
        tmo = 0;
        while (init_done !== level) begin
            @(negedge clk);
            tmo++;
            if (tmo > TIMEOUT) abort_run(what);
        end
    endtask

    task automatic check_status();
        logic [CNT_WID-1:0] exp_fill;
        exp_fill = CNT_WID'(model_keys.size());
        if (fill !== exp_fill) begin
            errors++;
            $display("ERR fill got 0x%0h expected 0x%0h", fill, exp_fill);
        end
        if (empty !== (model_keys.size() == 0)) begin
            errors++;
            $display("ERR empty got 0x%0h expected 0x%0h", empty, model_keys.size() == 0);
        end
        if (full !== (model_keys.size() == SIZE)) begin
            errors++;
            $display("ERR full got 0x%0h expected 0x%0h", full, model_keys.size() == SIZE);
        end
    endtask

    // --------------------------------------------------
    // Command and response channels
    // --------------------------------------------------
    task automatic send_command(input db_op_t op, input logic [KEY_WID-1:0] key,
                                input logic [VALUE_WID-1:0] value);
        int tmo;
        tmo       = 0;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_key   = key;
        cmd_value = value;
        while (!cmd_ready) begin
            @(negedge clk);
            tmo++;
            if (tmo > TIMEOUT) abort_run("command was never accepted");
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        commands++;
    endtask

    // Random rsp_ready gives back-pressure
    task automatic take_response(output logic hit, output logic error,
                                 output logic [KEY_WID-1:0] key,
                                 output logic [VALUE_WID-1:0] value);
        int   tmo;
        logic done;
        tmo  = 0;
        done = 1'b0;
        while (!done) begin
            rng       = xorshift(rng);
            rsp_ready = (rng[1:0] != 2'b00);
            if (rsp_valid && rsp_ready) begin
                hit   = rsp_hit;
                error = rsp_error;
                key   = rsp_key;
                value = rsp_value;
                done  = 1'b1;
            end
            @(negedge clk);
            tmo++;
            if (tmo > TIMEOUT) abort_run("no response arrived for an accepted command");
        end
        rsp_ready = 1'b0;
        responses++;
        if (rsp_valid) begin
            errors++;
            $display("Response still valid after it was accepted");
        end
    endtask

    // --------------------------------------------------
    // One command against the model
    // --------------------------------------------------
    task automatic run_command(input db_op_t op, input logic [KEY_WID-1:0] key,
                               input logic [VALUE_WID-1:0] value);
        logic                 exp_hit;
        logic                 exp_error;
        logic [KEY_WID-1:0]   exp_key;
        logic [VALUE_WID-1:0] exp_value;
        logic                 got_hit;
        logic                 got_error;
        logic [KEY_WID-1:0]   got_key;
        logic [VALUE_WID-1:0] got_value;
        exp_hit   = 1'b0;
        exp_error = 1'b0;
        exp_key   = '0;
        exp_value = '0;
        case (op)
            OP_PUSH: begin
                if (model_keys.size() == SIZE) begin
                    exp_error = 1'b1;
                end else begin
                    model_keys.push_front(key);
                    model_values.push_front(value);
                end
            end
            OP_POP: begin
                if (model_keys.size() == 0) begin
                    exp_error = 1'b1;
                end else begin
                    exp_hit   = 1'b1;
                    exp_key   = model_keys.pop_back();
                    exp_value = model_values.pop_back();
                end
            end
            default: begin
                // Walk down so the newest match is kept
                for (int i = model_keys.size() - 1; i >= 0; i--) begin
                    if (model_keys[i] == key) begin
                        exp_hit   = 1'b1;
                        exp_key   = model_keys[i];
                        exp_value = model_values[i];
                    end
                end
            end
        endcase
        send_command(op, key, value);
        take_response(got_hit, got_error, got_key, got_value);
        if (got_error !== exp_error) begin
            errors++;
            $display("ERR rsp_error got 0x%0h expected 0x%0h", got_error, exp_error);
        end
        if (got_hit !== exp_hit) begin
            errors++;
            $display("ERR rsp_hit got 0x%0h expected 0x%0h", got_hit, exp_hit);
        end
        if (got_key !== exp_key) begin
            errors++;
            $display("ERR rsp_key got 0x%0h expected 0x%0h", got_key, exp_key);
        end
        if (got_value !== exp_value) begin
            errors++;
            $display("ERR rsp_value got 0x%0h expected 0x%0h", got_value, exp_value);
        end
        check_status();
    endtask

    task automatic clear_stash();
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        wait_init(1'b0, "init_done did not fall after init");
        wait_init(1'b1, "init_done did not rise after init");
        model_keys.delete();
        model_values.delete();
        check_status();
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        rng       = 32'hb2a6;
        errors    = 0;
        commands  = 0;
        responses = 0;
        __srst    = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_PUSH;
        cmd_key   = '0;
        cmd_value = '0;
        rsp_ready = 1'b0;
        init      = 1'b0;
        repeat (8) @(negedge clk);
        __srst = 1'b0;
        wait_init(1'b1, "init_done never rose after reset");
        check_status();

        // Pop on an empty stash
        run_command(OP_POP, '0, '0);

        // Ordered pushes and pops
        for (int i = 0; i < 5; i++) begin
            rng = xorshift(rng);
            run_command(OP_PUSH, KEY_WID'(rng[2:0]), rng[31:16]);
        end
        for (int i = 0; i < 5; i++) begin
            run_command(OP_POP, '0, '0);
        end

        // Overfill, look up, then drain
        for (int i = 0; i < SIZE + 2; i++) begin
            rng = xorshift(rng);
            run_command(OP_PUSH, KEY_WID'(rng[2:0]), rng[31:16]);
        end
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            run_command(OP_LOOKUP, KEY_WID'(rng[3:0]), '0);
        end
        for (int i = 0; i < SIZE + 1; i++) begin
            run_command(OP_POP, '0, '0);
        end

        // Random mix, keys 8 and up never stored
        for (int i = 0; i < 200; i++) begin
            rng = xorshift(rng);
            case (rng[9:8])
                2'd0:    run_command(OP_PUSH, KEY_WID'(rng[2:0]), rng[31:16]);
                2'd1:    run_command(OP_POP, '0, '0);
                default: run_command(OP_LOOKUP, KEY_WID'(rng[3:0]), '0);
            endcase
        end

        // Init clears everything stored before
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            run_command(OP_PUSH, KEY_WID'(i), rng[31:16]);
        end
        clear_stash();
        for (int i = 0; i < 8; i++) begin
            run_command(OP_LOOKUP, KEY_WID'(i), '0);
        end

        $display("Errors: %0d, commands: %0d, responses: %0d", errors, commands, responses);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : db_stash_tb

// File: vlog.f
rtl/db_pkg.sv
rtl/db_intf.sv
rtl/db_fifo_ctrl.sv
rtl/db_stash_fifo.sv
rtl/db_core.sv
rtl/db_stash_top.sv
verif/db_stash_properties.sv
verif/db_stash_tb.sv

// File: Makefile
# Verilator build and run for the key-value stash

VERILATOR   ?= verilator
TOP         ?= db_stash_tb
FILELIST    ?= vlog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert
LINT_FLAGS  ?= -Wall
PASS_STRING ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_STRING)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
